// ==== logic/rs_macros.svh ====
`ifndef RS_MACROS_SVH
`define RS_MACROS_SVH

// Operand and result width
`define RS_DATA_W 32

// Physical register number width
`define RS_PREG_W 6

// Decoded control bundle
`define RS_CTRL_W 11

// Producer tag width, wide enough for the ready code
`define RS_TAG_W 3

// Common data bus channels watched by the station
`define RS_CDB_CHANNELS 4

`endif

// ==== logic/cdb_pkg.sv ====
`include "rs_macros.svh"

package cdb_pkg;

    // ============================
    // Common data bus payload
    // ============================

    // Tag of the unit that will produce an operand
    typedef logic [`RS_TAG_W-1:0] tag_t;

    // Operand value is already present
    localparam tag_t TAG_READY = 3'b111;

    // Load channel, also matches on destination register
    localparam tag_t TAG_LOAD = 3'b011;

    typedef logic [`RS_DATA_W-1:0] data_t;

    typedef logic [`RS_PREG_W-1:0] preg_t;

endpackage

// ==== logic/rs_types_pkg.sv ====
`include "rs_macros.svh"

package rs_types_pkg;

    // ============================
    // Held instruction context
    // ============================

    // Decoded control bits passed through to the unit
    typedef logic [`RS_CTRL_W-1:0] ctrl_t;

    // Everything that travels with the instruction except its operands
    typedef struct packed {
        ctrl_t          ctrl;
        // Instruction address
        cdb_pkg::data_t pc;
        // Destination physical register
        cdb_pkg::preg_t rd;
        // Value written by a store
        cdb_pkg::data_t store_data;
    } inst_ctx_t;

endpackage

// ==== logic/cdb_if.sv ====
`timescale 1ns/1ps

`include "rs_macros.svh"

// Common data bus seen by the station, one strobe per channel
interface cdb_if;

    // Result present on the channel this cycle
    logic [`RS_CDB_CHANNELS-1:0] valid;

    // Result value per channel
    cdb_pkg::data_t [`RS_CDB_CHANNELS-1:0] data;

    // Destination register per channel, checked on the load channel
    cdb_pkg::preg_t [`RS_CDB_CHANNELS-1:0] dest;

    // Side that puts results on the bus
    modport driver (
        output valid,
        output data,
        output dest
    );

    // Side that watches the bus for wake-up
    modport listener (
        input valid,
        input data,
        input dest
    );

endinterface

// ==== logic/operand_slot.sv ====
`timescale 1ns/1ps

`include "rs_macros.svh"

module operand_slot (
    input  logic           clk,
    input  logic           reset,
    input  logic           load,
    input  cdb_pkg::tag_t  tag_in,
    input  cdb_pkg::data_t data_in,
    cdb_if.listener        cdb,
    output logic           ready,
    output cdb_pkg::data_t value
);

    cdb_pkg::tag_t  tag_q;
    cdb_pkg::data_t data_q;
    cdb_pkg::data_t bus_value;
    logic           waiting;
    logic           hit;

    assign waiting = (tag_q != cdb_pkg::TAG_READY);

    // ============================
    // Bus wake-up
    // ============================

    always_comb begin
        logic chan_match;
        hit       = 1'b0;
        bus_value = data_q;
        for (int i = 0; i < `RS_CDB_CHANNELS; i++) begin
            chan_match = cdb.valid[i] && (tag_q == cdb_pkg::tag_t'(i));
            // Load channel also needs the register held in the data field
            if (cdb_pkg::tag_t'(i) == cdb_pkg::TAG_LOAD) begin
                chan_match = chan_match && (cdb.dest[i] == data_q[`RS_PREG_W-1:0]);
            end
            // Lowest matching channel wins
            if (waiting && chan_match && !hit) begin
                hit       = 1'b1;
                bus_value = cdb.data[i];
            end
        end
    end

    // Resolved now, either earlier or by this cycle's strobe
    assign ready = !waiting || hit;
    assign value = hit ? bus_value : data_q;

    // Tag tracking
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            tag_q <= cdb_pkg::TAG_READY;
        end else if (load) begin
            tag_q <= tag_in;
        end else if (hit) begin
            tag_q <= cdb_pkg::TAG_READY;
        end
    end

    // Operand value, or the awaited register number on a load wait
    always_ff @(posedge clk) begin
        if (load) begin
            data_q <= data_in;
        end else if (hit) begin
            data_q <= bus_value;
        end
    end

endmodule

// ==== logic/rs_control.sv ====
`timescale 1ns/1ps

module rs_control (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    dispatch_valid,
    output logic                    dispatch_ready,
    input  rs_types_pkg::inst_ctx_t dispatch_ctx,
    input  cdb_pkg::tag_t           op_a_tag,
    input  cdb_pkg::tag_t           op_b_tag,
    input  logic                    a_ready,
    input  logic                    b_ready,
    input  logic                    issue_ready,
    output logic                    load,
    output logic                    issue_fire,
    output logic                    issue_direct,
    output rs_types_pkg::inst_ctx_t held_ctx
);

    logic enable;
    logic occupied;
    logic accept;
    logic direct_ok;
    logic stored_fire;

    // ============================
    // Dispatch acceptance
    // ============================

    // Both operands present at decode
    assign direct_ok = (op_a_tag == cdb_pkg::TAG_READY) && (op_b_tag == cdb_pkg::TAG_READY);

    // Entry free and unit able to take a direct issue
    assign dispatch_ready = enable && !occupied && issue_ready;
    assign accept         = dispatch_valid && dispatch_ready;

    // Instruction must wait, so slots capture operands
    assign load = accept && !direct_ok;

    // ============================
    // Issue decision
    // ============================

    // Held entry goes once both slots resolve
    assign stored_fire = occupied && a_ready && b_ready && issue_ready;

    // Direct path bypasses the entry entirely
    assign issue_direct = accept && direct_ok;

    // Never both at once, accept needs a free entry
    assign issue_fire = stored_fire || issue_direct;

    // Enable rises one cycle out of reset, entry tracks occupancy
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            enable   <= 1'b0;
            occupied <= 1'b0;
        end else begin
            enable <= 1'b1;
            if (load) begin
                occupied <= 1'b1;
            end else if (stored_fire) begin
                occupied <= 1'b0;
            end
        end
    end

    // Context captured with the operands
    always_ff @(posedge clk) begin
        if (load) begin
            held_ctx <= dispatch_ctx;
        end
    end

endmodule

// ==== logic/issue_stage.sv ====
`timescale 1ns/1ps

module issue_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    issue_fire,
    input  logic                    issue_direct,
    input  rs_types_pkg::inst_ctx_t dispatch_ctx,
    input  rs_types_pkg::inst_ctx_t held_ctx,
    input  cdb_pkg::data_t          op_a_data,
    input  cdb_pkg::data_t          op_b_data,
    input  cdb_pkg::data_t          slot_a_value,
    input  cdb_pkg::data_t          slot_b_value,
    input  logic                    issue_ready,
    input  cdb_pkg::data_t          fu_result,
    output logic                    issue_valid,
    output rs_types_pkg::inst_ctx_t issue_ctx,
    output cdb_pkg::data_t          issue_a,
    output cdb_pkg::data_t          issue_b,
    output logic                    cdb_out_valid,
    output cdb_pkg::data_t          cdb_out_data,
    output cdb_pkg::preg_t          cdb_out_dest
);

    // ============================
    // Registered issue
    // ============================

    // Single-cycle pulse per fired instruction
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= issue_fire;
        end
    end

    // Decode fields on a direct issue, else the held entry
    always_ff @(posedge clk) begin
        if (issue_fire) begin
            if (issue_direct) begin
                issue_ctx <= dispatch_ctx;
                issue_a   <= op_a_data;
                issue_b   <= op_b_data;
            end else begin
                issue_ctx <= held_ctx;
                issue_a   <= slot_a_value;
                issue_b   <= slot_b_value;
            end
        end
    end

    // ============================
    // Own result broadcast
    // ============================

    // Unit result goes out in the cycle it accepts the issue
    assign cdb_out_valid = issue_valid && issue_ready;
    assign cdb_out_data  = fu_result;
    assign cdb_out_dest  = issue_ctx.rd;

endmodule

// ==== logic/rs_unit.sv ====
`timescale 1ns/1ps

module rs_unit (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    dispatch_valid,
    output logic                    dispatch_ready,
    input  rs_types_pkg::ctrl_t     ctrl,
    input  cdb_pkg::data_t          pc,
    input  cdb_pkg::preg_t          rd,
    input  cdb_pkg::data_t          store_data,
    input  cdb_pkg::tag_t           op_a_tag,
    input  cdb_pkg::tag_t           op_b_tag,
    input  cdb_pkg::data_t          op_a_data,
    input  cdb_pkg::data_t          op_b_data,
    input  logic                    cdb_valid_0,
    input  logic                    cdb_valid_1,
    input  logic                    cdb_valid_2,
    input  logic                    cdb_valid_3,
    input  cdb_pkg::data_t          cdb_data_0,
    input  cdb_pkg::data_t          cdb_data_1,
    input  cdb_pkg::data_t          cdb_data_2,
    input  cdb_pkg::data_t          cdb_data_3,
    input  cdb_pkg::preg_t          cdb_dest_0,
    input  cdb_pkg::preg_t          cdb_dest_1,
    input  cdb_pkg::preg_t          cdb_dest_2,
    input  cdb_pkg::preg_t          cdb_dest_3,
    output logic                    issue_valid,
    input  logic                    issue_ready,
    output rs_types_pkg::inst_ctx_t issue_ctx,
    output cdb_pkg::data_t          issue_a,
    output cdb_pkg::data_t          issue_b,
    input  cdb_pkg::data_t          fu_result,
    output logic                    cdb_out_valid,
    output cdb_pkg::data_t          cdb_out_data,
    output cdb_pkg::preg_t          cdb_out_dest
);

    rs_types_pkg::inst_ctx_t dispatch_ctx;
    rs_types_pkg::inst_ctx_t held_ctx;
    cdb_pkg::data_t          slot_a_value;
    cdb_pkg::data_t          slot_b_value;
    logic                    a_ready;
    logic                    b_ready;
    logic                    load;
    logic                    issue_fire;
    logic                    issue_direct;

    // ============================
    // Bus and decode packing
    // ============================

    cdb_if cdb_bus ();

    assign cdb_bus.valid = {cdb_valid_3, cdb_valid_2, cdb_valid_1, cdb_valid_0};
    assign cdb_bus.data  = {cdb_data_3, cdb_data_2, cdb_data_1, cdb_data_0};
    assign cdb_bus.dest  = {cdb_dest_3, cdb_dest_2, cdb_dest_1, cdb_dest_0};

    assign dispatch_ctx = '{ctrl: ctrl, pc: pc, rd: rd, store_data: store_data};

    // ============================
    // Operand slots and control
    // ============================

    operand_slot slot_a (
        .clk(clk), .reset(reset), .load(load), .tag_in(op_a_tag), .data_in(op_a_data),
        .cdb(cdb_bus.listener), .ready(a_ready), .value(slot_a_value)
    );

    operand_slot slot_b (
        .clk(clk), .reset(reset), .load(load), .tag_in(op_b_tag), .data_in(op_b_data),
        .cdb(cdb_bus.listener), .ready(b_ready), .value(slot_b_value)
    );

    rs_control rs_ctrl_i (
        .clk(clk), .reset(reset), .dispatch_valid(dispatch_valid),
        .dispatch_ready(dispatch_ready), .dispatch_ctx(dispatch_ctx),
        .op_a_tag(op_a_tag), .op_b_tag(op_b_tag), .a_ready(a_ready), .b_ready(b_ready),
        .issue_ready(issue_ready), .load(load), .issue_fire(issue_fire),
        .issue_direct(issue_direct), .held_ctx(held_ctx)
    );

    // Registered issue and result broadcast
    issue_stage issue_i (
        .clk(clk), .reset(reset), .issue_fire(issue_fire), .issue_direct(issue_direct),
        .dispatch_ctx(dispatch_ctx), .held_ctx(held_ctx),
        .op_a_data(op_a_data), .op_b_data(op_b_data),
        .slot_a_value(slot_a_value), .slot_b_value(slot_b_value),
        .issue_ready(issue_ready), .fu_result(fu_result), .issue_valid(issue_valid),
        .issue_ctx(issue_ctx), .issue_a(issue_a), .issue_b(issue_b),
        .cdb_out_valid(cdb_out_valid), .cdb_out_data(cdb_out_data),
        .cdb_out_dest(cdb_out_dest)
    );

endmodule

// ==== tests/rs_unit_assert.sv ====
`timescale 1ns/1ps

module rs_unit_assert (
    input logic clk,
    input logic reset,
    input logic occupied,
    input logic dispatch_ready,
    input logic issue_valid,
    input logic issue_ready,
    input logic cdb_out_valid
);

    // Number of failed properties
    int assert_errors = 0;

    // ============================
    // Station protocol properties
    // ============================

    // A held entry blocks new dispatch
    occupied_blocks_dispatch: assert property (@(posedge clk) disable iff (!reset)
        occupied |-> !dispatch_ready)
        else begin
            $error("dispatch_ready is high while the entry is occupied");
            assert_errors++;
        end

    // Own result only goes out with an accepted issue
    broadcast_needs_issue: assert property (@(posedge clk) disable iff (!reset)
        cdb_out_valid |-> (issue_valid && issue_ready))
        else begin
            $error("cdb_out_valid is high without issue_valid and issue_ready");
            assert_errors++;
        end

    issue_valid_known: assert property (@(posedge clk) disable iff (!reset)
        !$isunknown(issue_valid))
        else begin
            $error("issue_valid is unknown after reset");
            assert_errors++;
        end

endmodule

// Occupancy lives inside the control block
bind rs_unit rs_unit_assert rs_unit_assert_i (
    .clk(clk), .reset(reset), .occupied(rs_ctrl_i.occupied),
    .dispatch_ready(dispatch_ready), .issue_valid(issue_valid),
    .issue_ready(issue_ready), .cdb_out_valid(cdb_out_valid)
);

// ==== tests/tb_rs_unit.sv ====
`timescale 1ns/1ps

module tb_rs_unit;

    // Reset, six tests of at most about 40 cycles each, then margin
    localparam int WATCHDOG_NS = (10 + 6 * 40) * 8 + 400;

    logic                    clk;
    logic                    reset;
    logic                    dispatch_valid;
    logic                    dispatch_ready;
    rs_types_pkg::ctrl_t     ctrl;
    cdb_pkg::data_t          pc;
    cdb_pkg::preg_t          rd;
    cdb_pkg::data_t          store_data;
    cdb_pkg::tag_t           op_a_tag;
    cdb_pkg::tag_t           op_b_tag;
    cdb_pkg::data_t          op_a_data;
    cdb_pkg::data_t          op_b_data;
    logic [3:0]              cdb_valid;
    cdb_pkg::data_t          cdb_data [4];
    cdb_pkg::preg_t          cdb_dest [4];
    logic                    issue_valid;
    logic                    issue_ready;
    rs_types_pkg::inst_ctx_t issue_ctx;
    cdb_pkg::data_t          issue_a;
    cdb_pkg::data_t          issue_b;
    cdb_pkg::data_t          fu_result;
    logic                    cdb_out_valid;
    cdb_pkg::data_t          cdb_out_data;
    cdb_pkg::preg_t          cdb_out_dest;
    int                      mismatches;
    int                      failures;

    rs_unit dut_i (
        .clk(clk), .reset(reset), .dispatch_valid(dispatch_valid),
        .dispatch_ready(dispatch_ready), .ctrl(ctrl), .pc(pc), .rd(rd),
        .store_data(store_data), .op_a_tag(op_a_tag), .op_b_tag(op_b_tag),
        .op_a_data(op_a_data), .op_b_data(op_b_data),
        .cdb_valid_0(cdb_valid[0]), .cdb_valid_1(cdb_valid[1]),
        .cdb_valid_2(cdb_valid[2]), .cdb_valid_3(cdb_valid[3]),
        .cdb_data_0(cdb_data[0]), .cdb_data_1(cdb_data[1]),
        .cdb_data_2(cdb_data[2]), .cdb_data_3(cdb_data[3]),
        .cdb_dest_0(cdb_dest[0]), .cdb_dest_1(cdb_dest[1]),
        .cdb_dest_2(cdb_dest[2]), .cdb_dest_3(cdb_dest[3]),
        .issue_valid(issue_valid), .issue_ready(issue_ready), .issue_ctx(issue_ctx),
        .issue_a(issue_a), .issue_b(issue_b), .fu_result(fu_result),
        .cdb_out_valid(cdb_out_valid), .cdb_out_data(cdb_out_data),
        .cdb_out_dest(cdb_out_dest)
    );

    // 8 ns clock
    always #4 clk = ~clk;

    // ============================
    // Compare tasks
    // ============================

    task automatic check_data(input string name, input cdb_pkg::data_t got,
                              input cdb_pkg::data_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_ctx(input string name, input rs_types_pkg::inst_ctx_t got,
                             input rs_types_pkg::inst_ctx_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_preg(input string name, input cdb_pkg::preg_t got,
                              input cdb_pkg::preg_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // ============================
    // Stimulus helpers
    // ============================

    function automatic rs_types_pkg::inst_ctx_t random_ctx();
        rs_types_pkg::inst_ctx_t c;
        c.ctrl       = rs_types_pkg::ctrl_t'($urandom);
        c.pc         = $urandom;
        c.rd         = cdb_pkg::preg_t'($urandom);
        c.store_data = $urandom;
        return c;
    endfunction

    // One accepted dispatch, decode fields scrambled afterwards
    task automatic dispatch(input rs_types_pkg::inst_ctx_t ctx, input cdb_pkg::tag_t tag_a,
                            input cdb_pkg::tag_t tag_b, input cdb_pkg::data_t a,
                            input cdb_pkg::data_t b);
        @(negedge clk);
        check_bit("dispatch_ready", dispatch_ready, 1'b1);
        @(posedge clk);
        dispatch_valid <= 1'b1;
        ctrl           <= ctx.ctrl;
        pc             <= ctx.pc;
        rd             <= ctx.rd;
        store_data     <= ctx.store_data;
        op_a_tag       <= tag_a;
        op_b_tag       <= tag_b;
        op_a_data      <= a;
        op_b_data      <= b;
        @(posedge clk);
        dispatch_valid <= 1'b0;
        pc             <= $urandom;
        op_a_data      <= $urandom;
        op_b_data      <= $urandom;
    endtask

    // Single-cycle strobe on one bus channel
    task automatic strobe(input logic [1:0] ch, input cdb_pkg::data_t value,
                          input cdb_pkg::preg_t dest);
        @(posedge clk);
        cdb_valid[ch] <= 1'b1;
        cdb_data[ch]  <= value;
        cdb_dest[ch]  <= dest;
        @(posedge clk);
        cdb_valid <= 4'b0000;
    endtask

    // Counts cycles from the end of the trigger to issue_valid
    task automatic wait_issue(input int expected, input string what);
        int n;
        n = 1;
        @(negedge clk);
        while (issue_valid !== 1'b1 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (issue_valid !== 1'b1) begin
            failures++;
            $display("%0t: %s never produced issue_valid", $time, what);
        end else if (n != expected) begin
            failures++;
            $display("%0t: %s issued after %0d cycles instead of %0d", $time, what, n, expected);
        end
    endtask

    // Issue must stay quiet for a few cycles
    task automatic expect_no_issue(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_bit("issue_valid", issue_valid, 1'b0);
        end
    endtask

    // ============================
    // Directed tests
    // ============================

    task automatic reset_behavior();
        repeat (10) @(posedge clk);
        check_bit("issue_valid", issue_valid, 1'b0);
        check_bit("cdb_out_valid", cdb_out_valid, 1'b0);
        check_bit("dispatch_ready", dispatch_ready, 1'b0);
        reset <= 1'b1;
        // Enable flag still low in the first cycle out of reset
        @(negedge clk);
        check_bit("dispatch_ready", dispatch_ready, 1'b0);
        @(negedge clk);
        check_bit("dispatch_ready", dispatch_ready, 1'b1);
    endtask

    task automatic direct_issue();
        rs_types_pkg::inst_ctx_t ctx;
        cdb_pkg::data_t          a;
        cdb_pkg::data_t          b;
        ctx = random_ctx();
        a   = $urandom;
        b   = $urandom;
        dispatch(ctx, cdb_pkg::TAG_READY, cdb_pkg::TAG_READY, a, b);
        wait_issue(1, "direct dispatch");
        check_ctx("issue_ctx", issue_ctx, ctx);
        check_data("issue_a", issue_a, a);
        check_data("issue_b", issue_b, b);
        // issue_valid is a single pulse
        expect_no_issue(1);
    endtask

    task automatic channel_wakeup();
        rs_types_pkg::inst_ctx_t ctx;
        cdb_pkg::data_t          b;
        cdb_pkg::data_t          v;
        ctx = random_ctx();
        b   = $urandom;
        v   = $urandom;
        dispatch(ctx, cdb_pkg::tag_t'(1), cdb_pkg::TAG_READY, $urandom, b);
        // Channel 0 carries another producer
        strobe(2'd0, $urandom, 6'h00);
        expect_no_issue(2);
        strobe(2'd1, v, 6'h00);
        wait_issue(1, "channel 1 wake-up");
        check_ctx("issue_ctx", issue_ctx, ctx);
        check_data("issue_a", issue_a, v);
        check_data("issue_b", issue_b, b);
    endtask

    task automatic load_channel_match();
        rs_types_pkg::inst_ctx_t ctx;
        cdb_pkg::data_t          b;
        cdb_pkg::data_t          v;
        ctx = random_ctx();
        b   = $urandom;
        v   = $urandom;
        // Waiting operand holds physical register 0x15
        dispatch(ctx, cdb_pkg::TAG_LOAD, cdb_pkg::TAG_READY, 32'h0000_0015, b);
        strobe(2'd3, $urandom, 6'h16);
        expect_no_issue(2);
        strobe(2'd3, v, 6'h15);
        wait_issue(1, "load channel wake-up");
        check_ctx("issue_ctx", issue_ctx, ctx);
        check_data("issue_a", issue_a, v);
        check_data("issue_b", issue_b, b);
    endtask

    task automatic back_pressure_hold();
        rs_types_pkg::inst_ctx_t ctx;
        cdb_pkg::data_t          b;
        cdb_pkg::data_t          v;
        ctx = random_ctx();
        b   = $urandom;
        v   = $urandom;
        dispatch(ctx, cdb_pkg::tag_t'(2), cdb_pkg::TAG_READY, $urandom, b);
        @(posedge clk);
        issue_ready <= 1'b0;
        strobe(2'd2, v, 6'h00);
        // Resolved but held, entry still blocks dispatch
        repeat (3) begin
            @(negedge clk);
            check_bit("issue_valid", issue_valid, 1'b0);
            check_bit("dispatch_ready", dispatch_ready, 1'b0);
        end
        @(posedge clk);
        issue_ready <= 1'b1;
        @(posedge clk);
        wait_issue(1, "entry released by issue_ready");
        check_ctx("issue_ctx", issue_ctx, ctx);
        check_data("issue_a", issue_a, v);
        check_data("issue_b", issue_b, b);
    endtask

    task automatic result_broadcast();
        rs_types_pkg::inst_ctx_t ctx;
        cdb_pkg::data_t          res;
        ctx = random_ctx();
        res = $urandom;
        @(posedge clk);
        fu_result <= res;
        dispatch(ctx, cdb_pkg::TAG_READY, cdb_pkg::TAG_READY, $urandom, $urandom);
        wait_issue(1, "broadcast dispatch");
        check_bit("cdb_out_valid", cdb_out_valid, 1'b1);
        check_data("cdb_out_data", cdb_out_data, res);
        check_preg("cdb_out_dest", cdb_out_dest, ctx.rd);
    endtask

    // ============================
    // Run control
    // ============================

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0t before the tests completed", $time);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(95));
        clk            = 1'b0;
        reset          = 1'b0;
        dispatch_valid = 1'b0;
        ctrl           = '0;
        pc             = '0;
        rd             = '0;
        store_data     = '0;
        op_a_tag       = cdb_pkg::TAG_READY;
        op_b_tag       = cdb_pkg::TAG_READY;
        op_a_data      = '0;
        op_b_data      = '0;
        cdb_valid      = 4'b0000;
        for (int i = 0; i < 4; i++) begin
            cdb_data[i] = '0;
            cdb_dest[i] = '0;
        end
        issue_ready    = 1'b1;
        fu_result      = '0;
        mismatches     = 0;
        failures       = 0;

        reset_behavior();
        direct_issue();
        channel_wakeup();
        load_channel_match();
        back_pressure_hold();
        result_broadcast();

        repeat (2) @(posedge clk);
        $display("Summary: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatches, failures, dut_i.rs_unit_assert_i.assert_errors);
        if (mismatches == 0 && failures == 0 && dut_i.rs_unit_assert_i.assert_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+logic
logic/cdb_pkg.sv
logic/rs_types_pkg.sv
logic/cdb_if.sv
logic/operand_slot.sv
logic/rs_control.sv
logic/issue_stage.sv
logic/rs_unit.sv
tests/rs_unit_assert.sv
tests/tb_rs_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_rs_unit -o sim_rs_unit

out=$(./obj_dir/sim_rs_unit)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "ALL CHECKS PASSED"; then
    exit 0
else
    exit 1
fi
